// File: logic/pkg_memory.sv
// Memory packet definitions

`default_nettype none

package pkg_memory;

  // ------------------------------
  // Field widths
  // ------------------------------

  // Byte address of the access
  typedef logic [31:0] mem_address_t;

  // Write data word
  typedef logic [31:0] mem_data_t;

  // Source requestor index, one per slot
  typedef logic [1:0] requestor_id_t;

  // ------------------------------
  // Command encoding
  // ------------------------------

  // Responses share the bus but never go to memory
  typedef enum logic [1:0] {
    CMD_MEM_READ     = 2'd0,
    CMD_MEM_WRITE    = 2'd1,
    CMD_MEM_RESPONSE = 2'd2
  } mem_cmd_e;

  // ------------------------------
  // Packet layout
  // ------------------------------

  // 68 bits, cmd in the top bits
  typedef struct packed {
    mem_cmd_e      cmd;
    requestor_id_t id;
    mem_address_t  address;
    mem_data_t     data;
  } memory_payload_t;

  // Valid bit in front of the payload
  typedef struct packed {
    logic            valid;
    memory_payload_t payload;
  } memory_packet_t;

endpackage : pkg_memory

`default_nettype wire

// File: logic/pkg_control.sv
// Request path control definitions

`default_nettype none

package pkg_control;

  // ------------------------------
  // Sizes
  // ------------------------------
  localparam int unsigned NUM_REQUESTORS = 4;
  localparam int unsigned FIFO_DEPTH     = 16;
  // Fill level for prog_full
  localparam int unsigned PROG_THRESH    = 12;
  // Busy phase after reset
  localparam int unsigned SETUP_CYCLES   = 4;

  // Occupancy 0..FIFO_DEPTH
  typedef logic [4:0] fifo_level_t;

  // ------------------------------
  // FIFO control and status
  // ------------------------------
  typedef struct packed {
    logic rd_en;
  } fifo_ctrl_in_t;

  typedef struct packed {
    logic full;
    logic empty;
    logic valid;
    logic prog_full;
    logic setup_busy;
  } fifo_status_t;

  typedef enum logic {
    FIFO_CLEARING,
    FIFO_READY
  } fifo_setup_e;

endpackage : pkg_control

`default_nettype wire

// File: logic/request_input_stage.sv
// Requestor holding slots

`default_nettype none
`timescale 1ns/100ps

module request_input_stage (
  input  logic                       ap_clk,
  input  logic                       areset_control,
  input  pkg_memory::memory_packet_t request_in [pkg_control::NUM_REQUESTORS-1:0],
  input  logic [pkg_control::NUM_REQUESTORS-1:0] grant,
  output pkg_memory::memory_packet_t slot_packets [pkg_control::NUM_REQUESTORS-1:0]
);

  // ------------------------------
  // One slot per requestor
  // ------------------------------
  for (genvar i = 0; i < pkg_control::NUM_REQUESTORS; i++) begin : g_slot

    // Full flag, set by the strobe and cleared by the grant
    always_ff @(posedge ap_clk) begin
      if (areset_control) begin
        slot_packets[i].valid <= 1'b0;
      end else if (grant[i]) begin
        slot_packets[i].valid <= 1'b0;
      end else if (request_in[i].valid) begin
        slot_packets[i].valid <= 1'b1;
      end
    end

    // Payload only captured into an empty slot
    always_ff @(posedge ap_clk) begin
      if (request_in[i].valid && !slot_packets[i].valid) begin
        slot_packets[i].payload <= request_in[i].payload;
      end
    end

    // Requestor must wait for its grant before the next strobe
    a_no_strobe_into_full : assert property (
      @(posedge ap_clk) disable iff (areset_control)
      request_in[i].valid |-> !slot_packets[i].valid
    ) else $error("strobe into full slot %0d", i);

  end : g_slot

endmodule : request_input_stage

`default_nettype wire

// File: logic/request_arbiter_rr.sv
// Round-robin request arbiter

`default_nettype none
`timescale 1ns/100ps

module request_arbiter_rr (
  input  logic                       ap_clk,
  input  logic                       areset_control,
  input  pkg_memory::memory_packet_t slot_packets [pkg_control::NUM_REQUESTORS-1:0],
  input  logic                       hold,
  output logic [pkg_control::NUM_REQUESTORS-1:0] grant,
  output pkg_memory::memory_packet_t win_packet
);

  logic [pkg_control::NUM_REQUESTORS-1:0] req;
  logic [pkg_control::NUM_REQUESTORS-1:0] grant_next;
  pkg_memory::requestor_id_t              last_winner;
  pkg_memory::requestor_id_t              pick;
  logic                                   found;

  // ------------------------------
  // Request vector
  // ------------------------------

  // Slot granted this cycle is still full and must be masked
  always_comb begin
    for (int i = 0; i < pkg_control::NUM_REQUESTORS; i++) begin
      req[i] = slot_packets[i].valid & ~grant[i];
    end
  end

  // Search starts one past the last winner
  always_comb begin
    pick  = last_winner;
    found = 1'b0;
    for (int off = 1; off <= pkg_control::NUM_REQUESTORS; off++) begin
      if (!found && req[(int'(last_winner) + off) % pkg_control::NUM_REQUESTORS]) begin
        found = 1'b1;
        pick  = pkg_memory::requestor_id_t'(
                  (int'(last_winner) + off) % pkg_control::NUM_REQUESTORS);
      end
    end
  end

  // No grant while the FIFO holds us off
  always_comb begin
    grant_next       = '0;
    grant_next[pick] = found & ~hold;
  end

  // ------------------------------
  // Registered grant and winner
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      grant            <= '0;
      win_packet.valid <= 1'b0;
      // Requestor 0 first after reset
      last_winner      <= pkg_memory::requestor_id_t'(pkg_control::NUM_REQUESTORS - 1);
    end else begin
      grant            <= grant_next;
      win_packet.valid <= |grant_next;
      if (|grant_next) begin
        last_winner <= pick;
      end
    end
  end

  always_ff @(posedge ap_clk) begin
    win_packet.payload <= slot_packets[pick].payload;
  end

  a_grant_onehot : assert property (
    @(posedge ap_clk) disable iff (areset_control) $onehot0(grant)
  ) else $error("grant not one-hot: %b", grant);

  // Winner carries the payload of the granted slot, which stays full this cycle
  for (genvar i = 0; i < pkg_control::NUM_REQUESTORS; i++) begin : g_win_check
    a_win_matches_grant : assert property (
      @(posedge ap_clk) disable iff (areset_control)
      grant[i] |-> win_packet.valid && slot_packets[i].valid
                   && win_packet.payload == slot_packets[i].payload
    ) else $error("win_packet does not match granted slot %0d", i);
  end : g_win_check

endmodule : request_arbiter_rr

`default_nettype wire

// File: logic/request_filter_stage.sv
// Response filter ahead of the FIFO

`default_nettype none
`timescale 1ns/100ps

module request_filter_stage (
  input  logic                        ap_clk,
  input  logic                        areset_control,
  input  pkg_memory::memory_packet_t  win_packet,
  output logic                        wr_en,
  output pkg_memory::memory_payload_t wr_payload
);

  logic forward;

  // ------------------------------
  // Push filter
  // ------------------------------

  // Responses have used their grant, dropped here
  assign forward = win_packet.payload.cmd != pkg_memory::CMD_MEM_RESPONSE;

  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      wr_en <= 1'b0;
    end else begin
      wr_en <= win_packet.valid & forward;
    end
  end

  // Payload follows wr_en by the same register stage
  always_ff @(posedge ap_clk) begin
    wr_payload <= win_packet.payload;
  end

endmodule : request_filter_stage

`default_nettype wire

// File: logic/request_fifo.sv
// Synchronous request FIFO

`default_nettype none
`timescale 1ns/100ps

module request_fifo (
  input  logic                        ap_clk,
  input  logic                        areset_control,
  input  logic                        wr_en,
  input  pkg_memory::memory_payload_t wr_payload,
  input  pkg_control::fifo_ctrl_in_t  fifo_ctrl_in,
  output pkg_memory::memory_payload_t dout,
  output pkg_control::fifo_status_t   status
);

  typedef logic [$clog2(pkg_control::FIFO_DEPTH)-1:0]   fifo_ptr_t;
  typedef logic [$clog2(pkg_control::SETUP_CYCLES)-1:0] setup_count_t;

  pkg_memory::memory_payload_t storage [pkg_control::FIFO_DEPTH-1:0];
  fifo_ptr_t                   wr_ptr;
  fifo_ptr_t                   rd_ptr;
  pkg_control::fifo_level_t    level;
  pkg_control::fifo_setup_e    setup_state;
  setup_count_t                setup_cnt;
  logic                        push;
  logic                        pop;
  logic                        valid_q;

  // ------------------------------
  // Setup sequence after reset
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      setup_state <= pkg_control::FIFO_CLEARING;
      setup_cnt   <= '0;
    end else if (setup_state == pkg_control::FIFO_CLEARING) begin
      if (setup_cnt == setup_count_t'(pkg_control::SETUP_CYCLES - 1)) begin
        setup_state <= pkg_control::FIFO_READY;
      end
      setup_cnt <= setup_cnt + 1'b1;
    end
  end

  // Writes ignored while clearing
  assign push = wr_en & (setup_state == pkg_control::FIFO_READY);
  // Read enable arrives already qualified by empty
  assign pop  = fifo_ctrl_in.rd_en;

  // ------------------------------
  // Pointers and occupancy
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control || setup_state == pkg_control::FIFO_CLEARING) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      level   <= '0;
      valid_q <= 1'b0;
    end else begin
      wr_ptr  <= wr_ptr + fifo_ptr_t'(push);
      rd_ptr  <= rd_ptr + fifo_ptr_t'(pop);
      level   <= level + pkg_control::fifo_level_t'(push) - pkg_control::fifo_level_t'(pop);
      valid_q <= pop;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (push) begin
      storage[wr_ptr] <= wr_payload;
    end
    if (pop) begin
      dout <= storage[rd_ptr];
    end
  end

  // Full two entries early, room for packets already past the arbiter
  always_comb begin
    status.full       = level >= pkg_control::fifo_level_t'(pkg_control::FIFO_DEPTH - 2);
    status.empty      = level == '0;
    status.valid      = valid_q;
    status.prog_full  = level >= pkg_control::fifo_level_t'(pkg_control::PROG_THRESH);
    status.setup_busy = setup_state == pkg_control::FIFO_CLEARING;
  end

  // Hold path from the flag to the arbiter must keep the storage from overflowing
  a_no_write_when_full : assert property (
    @(posedge ap_clk) disable iff (areset_control)
    push |-> level != pkg_control::fifo_level_t'(pkg_control::FIFO_DEPTH)
  ) else $error("write into full FIFO");

  a_no_pop_when_empty : assert property (
    @(posedge ap_clk) disable iff (areset_control) pop |-> !status.empty
  ) else $error("pop from empty FIFO");

endmodule : request_fifo

`default_nettype wire

// File: logic/request_arbiter_top.sv
// Four-to-one memory request arbiter

`default_nettype none
`timescale 1ns/100ps

module request_arbiter_top (
  input  logic                       ap_clk,
  input  logic                       areset_control,
  input  pkg_memory::memory_packet_t request_in [pkg_control::NUM_REQUESTORS-1:0],
  input  pkg_control::fifo_ctrl_in_t fifo_ctrl_in,
  output logic [pkg_control::NUM_REQUESTORS-1:0] grant,
  output pkg_memory::memory_packet_t request_out,
  output pkg_control::fifo_status_t  fifo_status,
  output logic                       fifo_setup
);

  pkg_memory::memory_packet_t             slot_packets [pkg_control::NUM_REQUESTORS-1:0];
  pkg_memory::memory_packet_t             win_packet;
  logic [pkg_control::NUM_REQUESTORS-1:0] arb_grant;
  logic                                   arb_hold;
  logic                                   wr_en;
  pkg_memory::memory_payload_t            wr_payload;
  pkg_memory::memory_payload_t            fifo_dout;
  pkg_control::fifo_ctrl_in_t             fifo_ctrl_reg;
  pkg_control::fifo_ctrl_in_t             fifo_ctrl_int;
  pkg_control::fifo_status_t              fifo_status_int;

  // ------------------------------
  // Input register
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      fifo_ctrl_reg <= '0;
    end else begin
      fifo_ctrl_reg <= fifo_ctrl_in;
    end
  end

  // Pop only with data present
  assign fifo_ctrl_int.rd_en = fifo_ctrl_reg.rd_en & ~fifo_status_int.empty;

  // No grants while full or still clearing
  assign arb_hold = fifo_status_int.full | fifo_status_int.setup_busy;

  // ------------------------------
  // Pipeline stages
  // ------------------------------
  request_input_stage u_input_stage (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .request_in     (request_in),
    .grant          (arb_grant),
    .slot_packets   (slot_packets)
  );

  request_arbiter_rr u_arbiter (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .slot_packets   (slot_packets),
    .hold           (arb_hold),
    .grant          (arb_grant),
    .win_packet     (win_packet)
  );

  request_filter_stage u_filter (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .win_packet     (win_packet),
    .wr_en          (wr_en),
    .wr_payload     (wr_payload)
  );

  request_fifo u_fifo (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .wr_en          (wr_en),
    .wr_payload     (wr_payload),
    .fifo_ctrl_in   (fifo_ctrl_int),
    .dout           (fifo_dout),
    .status         (fifo_status_int)
  );

  // ------------------------------
  // Output registers
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_control) begin
      grant             <= '0;
      request_out.valid <= 1'b0;
      fifo_status       <= '{full: 1'b0, empty: 1'b1, valid: 1'b0,
                             prog_full: 1'b0, setup_busy: 1'b1};
      fifo_setup        <= 1'b1;
    end else begin
      grant             <= arb_grant;
      request_out.valid <= fifo_status_int.valid;
      fifo_status       <= fifo_status_int;
      fifo_setup        <= fifo_status_int.setup_busy;
    end
  end

  always_ff @(posedge ap_clk) begin
    request_out.payload <= fifo_dout;
  end

endmodule : request_arbiter_top

`default_nettype wire

// File: testbench/tb_request_model.svh
// Request path reference model

`ifndef TB_REQUEST_MODEL_SVH
`define TB_REQUEST_MODEL_SVH

// Expected payloads, one queue per source requestor
pkg_memory::memory_payload_t expected_q [pkg_control::NUM_REQUESTORS][$];

// Run totals
int unsigned sent_count     = 0;
int unsigned response_count = 0;
int unsigned received_count = 0;

// Responses use a grant but never reach the output
function automatic bit expected_forward(input pkg_memory::mem_cmd_e cmd);
  return cmd != pkg_memory::CMD_MEM_RESPONSE;
endfunction

// Accepted packet, queued only when it must come out
function automatic void record_sent(input pkg_memory::memory_payload_t payload);
  sent_count++;
  if (expected_forward(payload.cmd)) begin
    expected_q[payload.id].push_back(payload);
  end else begin
    response_count++;
  end
endfunction

// Packets still owed by the DUT
function automatic int unsigned outstanding();
  int unsigned total;
  total = 0;
  for (int i = 0; i < pkg_control::NUM_REQUESTORS; i++) begin
    total += expected_q[i].size();
  end
  return total;
endfunction

`endif

// File: testbench/tb_request_arbiter.sv
// Request arbiter testbench

`default_nettype none
`timescale 1ns/100ps

module tb_request_arbiter;

  localparam int unsigned SEED           = 32'hc64a4863;
  localparam int unsigned SINGLE_COUNT   = 8;
  localparam int unsigned CONTEND_COUNT  = 10;
  localparam int unsigned MIXED_COUNT    = 8;
  localparam int unsigned BACKLOG_COUNT  = 6;
  localparam int unsigned TOTAL_PACKETS  = SINGLE_COUNT + pkg_control::NUM_REQUESTORS
                                           * (CONTEND_COUNT + MIXED_COUNT + BACKLOG_COUNT);
  localparam int unsigned TIMEOUT_CYCLES = 40 * TOTAL_PACKETS + 200;

  logic                                   ap_clk;
  logic                                   areset_control;
  pkg_memory::memory_packet_t             request_in [pkg_control::NUM_REQUESTORS-1:0];
  pkg_control::fifo_ctrl_in_t             fifo_ctrl_in;
  logic [pkg_control::NUM_REQUESTORS-1:0] grant;
  pkg_memory::memory_packet_t             request_out;
  pkg_control::fifo_status_t              fifo_status;
  logic                                   fifo_setup;

  string                       test_name = "reset";
  int unsigned                 cycle = 0;
  int unsigned                 grant_count = 0;
  int unsigned                 prog_full_cycle = 0;
  int unsigned                 full_cycle = 0;
  int unsigned                 setup_wait;
  int unsigned                 mark_sent;
  int unsigned                 mark_resp;
  int unsigned                 mark_recv;
  int unsigned                 mark_grant;
  logic                        full_prev = 1'b0;
  pkg_memory::memory_payload_t exp_payload;

  `include "tb_request_model.svh"

  request_arbiter_top dut (
    .ap_clk         (ap_clk),
    .areset_control (areset_control),
    .request_in     (request_in),
    .fifo_ctrl_in   (fifo_ctrl_in),
    .grant          (grant),
    .request_out    (request_out),
    .fifo_status    (fifo_status),
    .fifo_setup     (fifo_setup)
  );

  initial begin
    ap_clk = 1'b0;
    forever #4 ap_clk = ~ap_clk;
  end

  // ------------------------------
  // Failure helpers
  // ------------------------------
  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("=== FAIL ===");
    $fatal(1, "Simulation stopped on the first failure");
  endtask

  task automatic check_equal(input string what, input logic [127:0] expected,
                             input logic [127:0] actual);
    if (expected !== actual) begin
      fail_run($sformatf("Error: %s %s expected %0h actual %0h",
                         test_name, what, expected, actual));
    end
  endtask

  // ------------------------------
  // Stimulus
  // ------------------------------

  // One packet at a time with the next strobe only after the grant
  task automatic run_requestor(input int unsigned id, input int unsigned count,
                               input int unsigned resp_pct);
    pkg_memory::memory_payload_t payload;
    int unsigned                 roll;
    for (int unsigned n = 0; n < count; n++) begin
      roll = $urandom_range(99, 0);
      if (roll < resp_pct) begin
        payload.cmd = pkg_memory::CMD_MEM_RESPONSE;
      end else if (roll[0]) begin
        payload.cmd = pkg_memory::CMD_MEM_WRITE;
      end else begin
        payload.cmd = pkg_memory::CMD_MEM_READ;
      end
      payload.id      = pkg_memory::requestor_id_t'(id);
      payload.address = $urandom;
      payload.data    = $urandom;
      @(negedge ap_clk);
      request_in[id].valid   = 1'b1;
      request_in[id].payload = payload;
      record_sent(payload);
      @(negedge ap_clk);
      request_in[id].valid = 1'b0;
      while (!grant[id]) @(negedge ap_clk);
    end
  endtask

  task automatic run_all(input int unsigned count, input int unsigned resp_pct);
    for (int i = 0; i < pkg_control::NUM_REQUESTORS; i++) begin
      automatic int unsigned id = i;
      fork
        run_requestor(id, count, resp_pct);
      join_none
    end
    wait fork;
  endtask

  // Quiet tail catches stray outputs
  task automatic wait_drain();
    while (outstanding() != 0) @(negedge ap_clk);
    repeat (10) @(negedge ap_clk);
    check_equal("empty after drain", 1, fifo_status.empty);
    check_equal("status valid after drain", 0, fifo_status.valid);
  endtask

  // ------------------------------
  // Monitors
  // ------------------------------

  // Grant shape, hold on full, flag history
  always @(negedge ap_clk) begin
    if (!areset_control) begin
      cycle++;
      check_equal("grant one-hot", 1, $onehot0(grant));
      // Registered full stops the grant one cycle later
      if (full_prev) check_equal("grant while full", 0, grant);
      grant_count += $countones(grant);
      if (fifo_status.prog_full && prog_full_cycle == 0) prog_full_cycle = cycle;
      if (fifo_status.full && full_cycle == 0) full_cycle = cycle;
      full_prev = fifo_status.full;
    end
  end

  // Compare each output against its id's queue
  always @(negedge ap_clk) begin
    if (!areset_control && request_out.valid) begin
      if (expected_q[request_out.payload.id].size() == 0) begin
        fail_run($sformatf("Output packet from requestor %0d was never expected (test %s)",
                           request_out.payload.id, test_name));
      end else begin
        exp_payload = expected_q[request_out.payload.id].pop_front();
        check_equal("cmd forwarded", 1, expected_forward(request_out.payload.cmd));
        check_equal("request_out payload", exp_payload, request_out.payload);
        check_equal("status valid with output", 1, fifo_status.valid);
        received_count++;
      end
    end
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge ap_clk);
    fail_run($sformatf("Timeout: run did not finish within %0d cycles, stuck in test %s",
                       TIMEOUT_CYCLES, test_name));
  end

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin
    void'($urandom(SEED));
    areset_control = 1'b1;
    fifo_ctrl_in   = '0;
    for (int i = 0; i < pkg_control::NUM_REQUESTORS; i++) begin
      request_in[i] = '0;
    end
    repeat (3) @(negedge ap_clk);
    areset_control = 1'b0;

    check_equal("fifo_setup", 1, fifo_setup);
    check_equal("empty", 1, fifo_status.empty);
    check_equal("full", 0, fifo_status.full);
    check_equal("prog_full", 0, fifo_status.prog_full);
    // Nothing may move during the setup phase
    setup_wait = 0;
    while (fifo_setup && setup_wait < 4 * pkg_control::SETUP_CYCLES) begin
      check_equal("grant in setup", 0, grant);
      check_equal("request_out valid in setup", 0, request_out.valid);
      check_equal("setup_busy in setup", 1, fifo_status.setup_busy);
      @(negedge ap_clk);
      setup_wait++;
    end
    check_equal("fifo_setup falls", 0, fifo_setup);
    check_equal("setup_busy falls", 0, fifo_status.setup_busy);
    check_equal("setup length", 1, setup_wait >= pkg_control::SETUP_CYCLES);

    test_name = "single_requestor";
    fifo_ctrl_in.rd_en = 1'b1;
    run_requestor(0, SINGLE_COUNT, 0);
    wait_drain();

    test_name = "all_requestors";
    run_all(CONTEND_COUNT, 0);
    wait_drain();

    test_name  = "response_filter";
    mark_sent  = sent_count;
    mark_resp  = response_count;
    mark_recv  = received_count;
    mark_grant = grant_count;
    run_all(MIXED_COUNT, 30);
    wait_drain();
    // Responses take a grant each but add nothing to the output
    check_equal("grants for mixed traffic", sent_count - mark_sent,
                grant_count - mark_grant);
    check_equal("forwarded mixed packets",
                (sent_count - mark_sent) - (response_count - mark_resp),
                received_count - mark_recv);

    test_name = "back_pressure";
    fifo_ctrl_in.rd_en = 1'b0;
    fork
      run_all(BACKLOG_COUNT, 0);
      begin
        while (!fifo_status.full) @(negedge ap_clk);
        repeat (20) @(negedge ap_clk);
        fifo_ctrl_in.rd_en = 1'b1;
      end
    join
    wait_drain();
    check_equal("prog_full before full", 1,
                prog_full_cycle != 0 && prog_full_cycle < full_cycle);

    // Every packet granted exactly once
    check_equal("grants per packet", sent_count, grant_count);
    check_equal("packets delivered", sent_count - response_count, received_count);
    $display("=== PASS ===");
    $finish;
  end

endmodule : tb_request_arbiter

`default_nettype wire

// File: sim.f
+incdir+testbench
logic/pkg_memory.sv
logic/pkg_control.sv
logic/request_input_stage.sv
logic/request_arbiter_rr.sv
logic/request_filter_stage.sv
logic/request_fifo.sv
logic/request_arbiter_top.sv
testbench/tb_request_arbiter.sv
